/* tb.f */
common/cpu_pkg.sv
logic/alu.sv
logic/decoder.sv
logic/registers.sv
bus/wb_master.sv
core/sequencer.sv
core/cpu.sv
tb/tb_clock.sv
tb/cpu_assert.sv
tb/cpu_tb.sv

/* Makefile */
SRCS := $(wildcard common/*.sv logic/*.sv bus/*.sv core/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb

obj_dir/Vcpu_tb: tb.f $(SRCS)
	verilator --binary --assert --top-module cpu_tb -f tb.f -o Vcpu_tb

clean:
	rm -rf obj_dir

/* tb/cpu_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam logic [31:0] reset_vector = 32'h40;
    localparam logic [31:0] op_reg = 32'h33;
    localparam logic [31:0] op_imm = 32'h13;
    localparam logic [31:0] op_load = 32'h03;
    localparam logic [31:0] op_lui = 32'h37;
    localparam logic [31:0] op_auipc = 32'h17;
    localparam logic [31:0] op_jalr = 32'h67;

    logic        clk;
    logic        reset;
    wb_req_t     wb_out;
    wb_rsp_t     wb_in;
    logic [31:0] mem [0:255];
    integer      seed;
    int          delay;
    logic [31:0] pc_emit;
    logic [31:0] res_off;
    // expected stores with one row per write access
    logic [31:0] exp_adr [$];
    logic [3:0]  exp_sel [$];
    logic [31:0] exp_dat [$];

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    cpu #(
        .reset_vector(reset_vector)
    ) u_cpu (
        .clk    (clk),
        .reset  (reset),
        .wb_in  (wb_in),
        .wb_out (wb_out)
    );

    bind wb_master cpu_assert u_assert (
        .clk    (clk),
        .reset  (reset),
        .wb_out (wb_out),
        .wb_in  (wb_in)
    );

    function automatic logic [31:0] r_type(input logic [31:0] f7, input logic [31:0] rs2,
                                           input logic [31:0] rs1, input logic [31:0] f3,
                                           input logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg[6:0]};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [31:0] rs1,
                                           input logic [31:0] f3, input logic [31:0] rd,
                                           input logic [31:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [31:0] rs2,
                                           input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [31:0] rs2,
                                           input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [31:0] rd,
                                           input logic [31:0] op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic put_word(input logic [31:0] w);
        mem[pc_emit[9:2]] = w;
        pc_emit = pc_emit + 4;
    endtask

    task automatic expect_store(input logic [31:0] adr, input logic [3:0] sel,
                                input logic [31:0] dat);
        exp_adr.push_back(adr);
        exp_sel.push_back(sel);
        exp_dat.push_back(dat);
    endtask

    // SW of a result register into the next word of the result area at 0x300
    task automatic store_result(input logic [31:0] rs, input logic [31:0] value);
        put_word(s_type(res_off, rs, 1, 2));
        expect_store(32'h300 + res_off, 4'hf, value);
        res_off = res_off + 4;
    endtask

    task automatic branch_case(input logic [31:0] f3, input logic [31:0] rs1,
                               input logic [31:0] rs2, input logic taken, input logic [31:0] id);
        put_word(b_type(12, rs2, rs1, f3));
        put_word(i_type(32'h200 + id, 0, 0, 9, op_imm));
        put_word(j_type(8, 0));
        put_word(i_type(32'h100 + id, 0, 0, 9, op_imm));
        store_result(9, taken ? 32'h100 + id : 32'h200 + id);
    endtask

    task automatic load_result(input logic [31:0] f3, input logic [31:0] off,
                               input logic [31:0] value);
        put_word(i_type(off, 10, f3, 4, op_load));
        store_result(4, value);
    endtask

    task automatic store_lane(input logic [31:0] f3, input logic [31:0] off,
                              input logic [3:0] sel, input logic [31:0] dat);
        put_word(s_type(off, 12, 11, f3));
        expect_store(32'h3f0, sel, dat);
    endtask

    task automatic build_program();
        logic [31:0] here;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hc0de0000 | i;
        end
        mem[32'h3e0 >> 2] = 32'h80f17f9c;
        pc_emit = reset_vector;
        res_off = 0;
        put_word(i_type(32'h300, 0, 0, 1, op_imm));
        put_word(i_type(-20, 0, 0, 2, op_imm));
        put_word(i_type(6, 0, 0, 3, op_imm));
        // x0 ignores writes
        put_word(i_type(5, 0, 0, 0, op_imm));
        store_result(0, 32'h0);
        put_word(r_type(0, 3, 2, 0, 4));
        store_result(4, 32'hfffffff2);
        put_word(r_type(32'h20, 2, 3, 0, 4));
        store_result(4, 32'h1a);
        put_word(r_type(0, 3, 3, 1, 4));
        store_result(4, 32'h180);
        put_word(r_type(0, 3, 2, 2, 4));
        store_result(4, 32'h1);
        put_word(r_type(0, 3, 2, 3, 4));
        store_result(4, 32'h0);
        put_word(r_type(0, 3, 2, 4, 4));
        store_result(4, 32'hffffffea);
        put_word(r_type(0, 3, 2, 5, 4));
        store_result(4, 32'h03ffffff);
        put_word(r_type(32'h20, 3, 2, 5, 4));
        store_result(4, 32'hffffffff);
        put_word(r_type(0, 3, 2, 6, 4));
        store_result(4, 32'hffffffee);
        put_word(r_type(0, 3, 2, 7, 4));
        store_result(4, 32'h4);
        put_word(i_type(100, 2, 0, 4, op_imm));
        store_result(4, 32'h50);
        put_word(i_type(-19, 2, 2, 4, op_imm));
        store_result(4, 32'h1);
        put_word(i_type(-1, 3, 3, 4, op_imm));
        store_result(4, 32'h1);
        put_word(i_type(-1, 3, 4, 4, op_imm));
        store_result(4, 32'hfffffff9);
        put_word(i_type(32'h70, 3, 6, 4, op_imm));
        store_result(4, 32'h76);
        put_word(i_type(32'hf0, 2, 7, 4, op_imm));
        store_result(4, 32'he0);
        put_word(i_type(28, 3, 1, 4, op_imm));
        store_result(4, 32'h60000000);
        put_word(i_type(28, 2, 5, 4, op_imm));
        store_result(4, 32'hf);
        put_word(i_type(32'h402, 2, 5, 4, op_imm));
        store_result(4, 32'hfffffffb);
        put_word(u_type(32'h12345, 4, op_lui));
        store_result(4, 32'h12345000);
        here = pc_emit;
        put_word(u_type(1, 4, op_auipc));
        store_result(4, here + 32'h1000);
        // jal over a stray store to address 0
        here = pc_emit;
        put_word(j_type(8, 5));
        put_word(s_type(0, 3, 0, 2));
        store_result(5, here + 4);
        // jalr with an odd offset lands on the even address
        here = pc_emit;
        put_word(u_type(0, 7, op_auipc));
        put_word(i_type(13, 7, 0, 8, op_jalr));
        put_word(s_type(0, 3, 0, 2));
        store_result(8, here + 8);
        put_word(32'h0ff0000f);
        branch_case(0, 3, 3, 1'b1, 0);
        branch_case(0, 2, 3, 1'b0, 1);
        branch_case(1, 2, 3, 1'b1, 2);
        branch_case(1, 3, 3, 1'b0, 3);
        branch_case(4, 2, 3, 1'b1, 4);
        branch_case(4, 3, 2, 1'b0, 5);
        branch_case(5, 3, 2, 1'b1, 6);
        branch_case(5, 2, 3, 1'b0, 7);
        branch_case(6, 3, 2, 1'b1, 8);
        branch_case(6, 2, 3, 1'b0, 9);
        branch_case(7, 2, 3, 1'b1, 10);
        branch_case(7, 3, 2, 1'b0, 11);
        put_word(i_type(32'h3e0, 0, 0, 10, op_imm));
        load_result(0, 0, 32'hffffff9c);
        load_result(4, 0, 32'h9c);
        load_result(0, 1, 32'h7f);
        load_result(4, 2, 32'hf1);
        load_result(0, 3, 32'hffffff80);
        load_result(1, 0, 32'h7f9c);
        load_result(1, 2, 32'hffff80f1);
        load_result(5, 2, 32'h80f1);
        load_result(2, 0, 32'h80f17f9c);
        put_word(i_type(32'h3f0, 0, 0, 11, op_imm));
        put_word(u_type(32'h12345, 12, op_lui));
        put_word(i_type(32'h6c7, 12, 0, 12, op_imm));
        store_lane(0, 0, 4'b0001, 32'hc7c7c7c7);
        store_lane(0, 1, 4'b0010, 32'hc7c7c7c7);
        store_lane(0, 2, 4'b0100, 32'hc7c7c7c7);
        store_lane(0, 3, 4'b1000, 32'hc7c7c7c7);
        store_lane(1, 0, 4'b0011, 32'h56c756c7);
        store_lane(1, 2, 4'b1100, 32'h56c756c7);
        // park the core
        put_word(j_type(0, 0));
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s: got %h, expected %h",
                     $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_for_fetch();
        int count;
        count = 0;
        while (wb_out.cyc !== 1'b1 && count < 100) begin
            @(negedge clk);
            count++;
        end
        if (wb_out.cyc !== 1'b1) begin
            $display("the first instruction fetch never started");
            $display("RESULT: FAIL");
            $fatal(1, "fetch timeout");
        end
    endtask

    task automatic wait_for_store(input int row);
        int   count;
        logic seen;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < 2000) begin
            @(negedge clk);
            seen = wb_out.cyc && wb_out.we && wb_in.ack;
            count++;
        end
        if (!seen) begin
            $display("store %0d to address %h never arrived", row, exp_adr[row]);
            $display("RESULT: FAIL");
            $fatal(1, "store timeout");
        end
    endtask

    initial begin
        seed      = 32'hd0b2f7c2;
        delay     <= 0;
        wb_in.ack <= 1'b0;
        wb_in.dat <= 32'h0;
    end

    // Wishbone slave memory with 0 to 3 wait cycles before ack
    always @(posedge clk) begin
        if (reset) begin
            wb_in.ack <= 1'b0;
            delay     <= $random(seed) & 3;
        end else if (wb_in.ack) begin
            wb_in.ack <= 1'b0;
            delay     <= $random(seed) & 3;
        end else if (wb_out.cyc && wb_out.stb) begin
            if (delay == 0) begin
                wb_in.ack <= 1'b1;
                if (wb_out.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_out.sel[b]) begin
                            mem[wb_out.adr[9:2]][8*b +: 8] = wb_out.dat[8*b +: 8];
                        end
                    end
                end else begin
                    wb_in.dat <= mem[wb_out.adr[9:2]];
                end
            end else begin
                delay <= delay - 1;
            end
        end
    end

    initial begin
        build_program();
        wait_for_fetch();
        check("first fetch address", wb_out.adr, reset_vector);
        check("first fetch we", {31'b0, wb_out.we}, 32'h0);
        for (int i = 0; i < exp_adr.size(); i++) begin
            wait_for_store(i);
            check($sformatf("store %0d address", i), wb_out.adr, exp_adr[i]);
            check($sformatf("store %0d sel", i), {28'b0, wb_out.sel}, {28'b0, exp_sel[i]});
            check($sformatf("store %0d data", i), wb_out.dat, exp_dat[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_assert (
    input logic             clk,
    input logic             reset,
    input cpu_pkg::wb_req_t wb_out,
    input cpu_pkg::wb_rsp_t wb_in
);

    // cyc and stb both drop in the cycle after ack
    a_end_after_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_out.stb && wb_in.ack) |=> (!wb_out.cyc && !wb_out.stb))
        else $error("bus cycle still open after ack");

    // request must not move until the slave acks
    a_hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_out.stb && !wb_in.ack) |=> (wb_out.stb && $stable(wb_out.adr)
        && $stable(wb_out.we) && $stable(wb_out.sel) && $stable(wb_out.dat)))
        else $error("bus request changed while waiting for ack");

    a_idle_in_reset: assert property (@(posedge clk) reset |=> !wb_out.cyc)
        else $error("cyc high during reset");

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    int cycles;

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        cycles = 0;
    end

    // 4 ns period
    always #2 clk = ~clk;

    // reset held for the first 8 rising edges
    always @(posedge clk) begin
        if (cycles < 8) begin
            cycles <= cycles + 1;
        end
        if (cycles == 7) begin
            reset <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* core/cpu.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu #(
    parameter logic [cpu_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::wb_rsp_t wb_in,
    output cpu_pkg::wb_req_t wb_out
);
    import cpu_pkg::*;

    dec_t        dec;
    logic        dec_en;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    alu_op_t     alu_op;
    logic [31:0] alu_result;
    logic        alu_lt;
    logic        alu_ltu;
    logic        alu_eq;
    logic        rd_we;
    logic [31:0] rd_data;
    bus_cmd_t    bus_cmd;
    logic        bus_busy;
    logic [31:0] bus_rdata;

    sequencer #(
        .reset_vector(reset_vector)
    ) u_seq (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .alu_result (alu_result),
        .alu_lt     (alu_lt),
        .alu_ltu    (alu_ltu),
        .alu_eq     (alu_eq),
        .bus_busy   (bus_busy),
        .bus_rdata  (bus_rdata),
        .dec_en     (dec_en),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .rd_we      (rd_we),
        .rd_data    (rd_data),
        .bus_cmd    (bus_cmd)
    );

    // fetched word comes straight from the bus unit
    decoder u_dec (
        .clk   (clk),
        .en    (dec_en),
        .instr (bus_rdata),
        .dec   (dec)
    );

    registers u_regs (
        .clk  (clk),
        .rs1  (dec.rs1),
        .rs2  (dec.rs2),
        .rd   (dec.rd),
        .we   (rd_we),
        .data (rd_data),
        .val1 (rs1_val),
        .val2 (rs2_val)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .lt     (alu_lt),
        .ltu    (alu_ltu),
        .eq     (alu_eq)
    );

    wb_master u_bus (
        .clk    (clk),
        .reset  (reset),
        .cmd    (bus_cmd),
        .busy   (bus_busy),
        .rdata  (bus_rdata),
        .wb_in  (wb_in),
        .wb_out (wb_out)
    );

endmodule

`default_nettype wire

/* core/sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module sequencer #(
    parameter logic [cpu_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::dec_t     dec,
    input  logic [31:0]       rs1_val,
    input  logic [31:0]       rs2_val,
    input  logic [31:0]       alu_result,
    input  logic              alu_lt,
    input  logic              alu_ltu,
    input  logic              alu_eq,
    input  logic              bus_busy,
    input  logic [31:0]       bus_rdata,
    output logic              dec_en,
    output logic [31:0]       alu_a,
    output logic [31:0]       alu_b,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              rd_we,
    output logic [31:0]       rd_data,
    output cpu_pkg::bus_cmd_t bus_cmd
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEM, BRANCH2
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic [31:0] pcnext;
    logic        nextpc_from_alu;
    logic        wb_from_alu;
    logic        wb_from_bus;
    // set once the bus command of this FETCH or MEM went out
    logic        issued;

    logic [31:0] next_pc;
    logic        first;
    logic        taken;
    alu_op_t     funct_op;
    bus_op_t     mem_op;

    assign next_pc = nextpc_from_alu ? alu_result : pcnext;
    assign first   = !issued && (state == FETCH || state == MEM);
    assign dec_en  = state == DECODE;

    // BGE, BNE and BGEU are the inverse of their pair
    assign taken = (dec.funct3[2] ? (dec.funct3[1] ? alu_ltu : alu_lt) : alu_eq)
                   ^ dec.funct3[0];

    always_comb begin
        case (dec.funct3)
            F3_ADD:  funct_op = (dec.opcode == OP && dec.funct7_5) ? SUB : ADD;
            F3_SLL:  funct_op = SLL;
            F3_SLT:  funct_op = SLT;
            F3_SLTU: funct_op = SLTU;
            F3_XOR:  funct_op = XOR;
            F3_SR:   funct_op = dec.funct7_5 ? SRA : SRL;
            F3_OR:   funct_op = OR;
            F3_AND:  funct_op = AND;
            default: funct_op = ADD;
        endcase
    end

    always_comb begin
        if (dec.opcode == STORE) begin
            case (dec.funct3)
                F3_SB:   mem_op = WRITEB;
                F3_SH:   mem_op = WRITEH;
                default: mem_op = WRITEW;
            endcase
        end else begin
            case (dec.funct3)
                F3_LB:   mem_op = READB;
                F3_LH:   mem_op = READH;
                F3_LBU:  mem_op = READBU;
                F3_LHU:  mem_op = READHU;
                default: mem_op = READW;
            endcase
        end
    end

    // operands; FETCH repeats the EXEC view for the deferred writeback
    always_comb begin
        alu_a  = rs1_val;
        alu_b  = rs2_val;
        alu_op = ADD;
        if (state == DECODE) begin
            // ALU is idle here, so it gives pc + 4
            alu_a = pc;
            alu_b = 32'd4;
        end else if (dec.opcode == BRANCH && state != EXEC) begin
            // branch target
            alu_a = pc;
            alu_b = dec.imm;
        end else begin
            case (dec.opcode)
                OP: begin
                    alu_op = funct_op;
                end
                OPIMM: begin
                    alu_b  = dec.imm;
                    alu_op = funct_op;
                end
                LOAD, STORE, JALR: begin
                    alu_b = dec.imm;
                end
                JAL, AUIPC: begin
                    alu_a = pc;
                    alu_b = dec.imm;
                end
                default: begin
                    alu_op = ADD;
                end
            endcase
        end
    end

    always_comb begin
        bus_cmd.en   = first;
        bus_cmd.op   = (state == MEM) ? mem_op : READW;
        bus_cmd.addr = (state == MEM) ? alu_result : {next_pc[31:1], 1'b0};
        bus_cmd.data = rs2_val;
    end

    always_comb begin
        rd_we   = 1'b0;
        rd_data = wb_from_bus ? bus_rdata : alu_result;
        if (state == FETCH && !issued) begin
            rd_we = wb_from_alu | wb_from_bus;
        end else if (state == EXEC && dec.opcode == LUI) begin
            rd_we   = 1'b1;
            rd_data = dec.imm;
        end else if (state == EXEC && (dec.opcode == JAL || dec.opcode == JALR)) begin
            // link value is the pc + 4 saved in DECODE
            rd_we   = 1'b1;
            rd_data = pcnext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= FETCH;
            issued          <= 1'b0;
            pc              <= reset_vector;
            pcnext          <= reset_vector;
            nextpc_from_alu <= 1'b0;
            wb_from_alu     <= 1'b0;
            wb_from_bus     <= 1'b0;
        end else begin
            case (state)
                FETCH, MEM: begin
                    if (!issued) begin
                        issued <= 1'b1;
                        if (state == FETCH) begin
                            pc          <= {next_pc[31:1], 1'b0};
                            wb_from_alu <= 1'b0;
                            wb_from_bus <= 1'b0;
                        end
                    end else if (!bus_busy) begin
                        issued <= 1'b0;
                        state  <= (state == FETCH) ? DECODE : FETCH;
                    end
                end
                DECODE: begin
                    pcnext          <= alu_result;
                    nextpc_from_alu <= 1'b0;
                    state           <= EXEC;
                end
                EXEC: begin
                    case (dec.opcode)
                        OP, OPIMM, AUIPC: begin
                            wb_from_alu <= 1'b1;
                            state       <= FETCH;
                        end
                        LOAD: begin
                            wb_from_bus <= 1'b1;
                            state       <= MEM;
                        end
                        STORE: begin
                            state <= MEM;
                        end
                        JAL, JALR: begin
                            // target taken now, before rd can change rs1
                            pcnext <= alu_result;
                            state  <= FETCH;
                        end
                        BRANCH: begin
                            nextpc_from_alu <= taken;
                            state           <= BRANCH2;
                        end
                        default: begin
                            state <= FETCH;
                        end
                    endcase
                end
                default: begin
                    state <= FETCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* bus/wb_master.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_master (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::bus_cmd_t cmd,
    output logic              busy,
    output logic [31:0]       rdata,
    input  cpu_pkg::wb_rsp_t  wb_in,
    output cpu_pkg::wb_req_t  wb_out
);
    import cpu_pkg::*;

    logic        cyc_q;
    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic [3:0]  sel_q;
    bus_op_t     op_q;
    logic [1:0]  lane_q;

    logic        is_write;
    logic [3:0]  sel_d;
    logic [31:0] dat_d;
    logic [31:0] shifted;
    logic [31:0] rdata_d;

    assign is_write = cmd.op inside {WRITEB, WRITEH, WRITEW};

    // lanes from access size and low address bits
    always_comb begin
        case (cmd.op)
            READB, READBU, WRITEB: begin
                sel_d = 4'b0001 << cmd.addr[1:0];
                dat_d = {4{cmd.data[7:0]}};
            end
            READH, READHU, WRITEH: begin
                sel_d = cmd.addr[1] ? 4'b1100 : 4'b0011;
                dat_d = {2{cmd.data[15:0]}};
            end
            default: begin
                sel_d = 4'b1111;
                dat_d = cmd.data;
            end
        endcase
    end

    // move the addressed lane down, then extend
    assign shifted = wb_in.dat >> {lane_q, 3'b000};

    always_comb begin
        case (op_q)
            READB:   rdata_d = {{24{shifted[7]}}, shifted[7:0]};
            READBU:  rdata_d = {24'b0, shifted[7:0]};
            READH:   rdata_d = {{16{shifted[15]}}, shifted[15:0]};
            READHU:  rdata_d = {16'b0, shifted[15:0]};
            default: rdata_d = wb_in.dat;
        endcase
    end

    // cycle stays open from the strobe until ack
    always_ff @(posedge clk) begin
        if (reset) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (cmd.en) begin
            cyc_q <= 1'b1;
            we_q  <= is_write;
        end else if (cyc_q && wb_in.ack) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.en) begin
            adr_q  <= {cmd.addr[31:2], 2'b00};
            dat_q  <= dat_d;
            sel_q  <= sel_d;
            op_q   <= cmd.op;
            lane_q <= cmd.addr[1:0];
        end
        if (cyc_q && wb_in.ack && !we_q) begin
            rdata <= rdata_d;
        end
    end

    assign busy = cyc_q;

    assign wb_out.adr = adr_q;
    assign wb_out.dat = dat_q;
    assign wb_out.sel = sel_q;
    assign wb_out.we  = we_q;
    assign wb_out.cyc = cyc_q;
    assign wb_out.stb = cyc_q;

endmodule

`default_nettype wire

/* logic/registers.sv */
`default_nettype none
`timescale 1ns/1ps

module registers (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               we,
    input  logic [31:0]        data,
    output logic [31:0]        val1,
    output logic [31:0]        val2
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    assign val1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign val2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= data;
        end
    end

endmodule

`default_nettype wire

/* logic/decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module decoder (
    input  logic          clk,
    input  logic          en,
    input  logic [31:0]   instr,
    output cpu_pkg::dec_t dec
);
    import cpu_pkg::*;

    instr_u      word;
    opcode_t     opcode;
    logic [31:0] imm;

    assign word   = instr;
    assign opcode = opcode_t'(word.r.opcode[6:2]);

    // immediate layout follows the format of the opcode
    always_comb begin
        case (opcode)
            STORE: begin
                imm = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
            end
            BRANCH: begin
                imm = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                       word.b.imm_10_5, word.b.imm_4_1, 1'b0};
            end
            LUI, AUIPC: begin
                imm = {word.u.imm, 12'b0};
            end
            JAL: begin
                imm = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                       word.j.imm_11, word.j.imm_10_1, 1'b0};
            end
            default: begin
                // OPIMM, LOAD, JALR and anything unknown
                imm = {{20{word.i.imm[11]}}, word.i.imm};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            dec.opcode   <= opcode;
            dec.rd       <= word.r.rd;
            dec.rs1      <= word.r.rs1;
            dec.rs2      <= word.r.rs2;
            dec.funct3   <= word.r.funct3;
            dec.funct7_5 <= word.r.funct7[5];
            dec.imm      <= imm;
        end
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  cpu_pkg::alu_op_t op,
    output logic [31:0]      result,
    output logic             lt,
    output logic             ltu,
    output logic             eq
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compares are always valid, branches read them directly
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;
    assign eq  = a == b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, lt};
            SLTU:    result = {31'b0, ltu};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // opcode bits [6:2], bits [1:0] are always 11
    typedef enum logic [4:0] {
        LOAD    = 5'b00000,
        MISCMEM = 5'b00011,
        OPIMM   = 5'b00100,
        AUIPC   = 5'b00101,
        STORE   = 5'b01000,
        OP      = 5'b01100,
        LUI     = 5'b01101,
        BRANCH  = 5'b11000,
        JALR    = 5'b11001,
        JAL     = 5'b11011
    } opcode_t;

    // funct3 of OP and OPIMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of loads and stores
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [2:0] {
        READB, READH, READW, READBU, READHU, WRITEB, WRITEH, WRITEW
    } bus_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, viewed in each encoding
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        opcode_t          opcode;
        reg_addr_t        rd;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        logic [2:0]       funct3;
        logic             funct7_5;
        logic [xlen-1:0]  imm;
    } dec_t;

    typedef struct packed {
        logic            en;
        bus_op_t         op;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } bus_cmd_t;

    typedef struct packed {
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat;
        logic [3:0]      sel;
        logic            we;
        logic            cyc;
        logic            stb;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
